// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = VideoTxBlockTb
FILELIST = all.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== VideoPixelGenUnit.sv ====
// Video pixel generator: raster scan with opaque rectangle compositing into RGB565
`default_nettype none

module VideoPixelGenUnit
	import VideoTxPkg::*;
#(
	parameter int pVHA       = 320,
	parameter int pVVA       = 240,
	parameter int pSquareNum = 2,
	localparam int lpPosW    = fPosWidth(pVHA, pVVA)
)(
	input  logic                      iSCLK,
	input  logic                      arstN,
	// Settings
	input  logic                      enable,
	input  logic [cDstColorDepth-1:0] backColor,
	input  logic [cUsiBusWidth-1:0]   sqLeft  [pSquareNum],
	input  logic [cUsiBusWidth-1:0]   sqRight [pSquareNum],
	input  logic [cUsiBusWidth-1:0]   sqTop   [pSquareNum],
	input  logic [cUsiBusWidth-1:0]   sqUnder [pSquareNum],
	input  logic [cDstColorDepth-1:0] sqColor [pSquareNum],
	input  logic [cAlphaWidth-1:0]    sqAlpha [pSquareNum],
	// Current line for status
	output logic [lpPosW-1:0]         vPos,
	// Pixel stream toward FIFO
	VideoStreamIf.source              out
);

	// --------------------------------------------------
	// Raster position and output stage
	// --------------------------------------------------
	logic [lpPosW-1:0]         qHPos;
	logic [lpPosW-1:0]         qVPos;
	// Frame in progress
	logic                      qRun;
	logic                      qVd;
	logic                      qFd;
	logic [cDstColorDepth-1:0] qPd;
	logic                      wLoad;
	logic [cDstColorDepth-1:0] wColor;
	logic [cUsiBusWidth-1:0]   wX;
	logic [cUsiBusWidth-1:0]   wY;

	// Output register empty or being taken
	assign wLoad = !qVd || out.rs;

	assign wX = cUsiBusWidth'(qHPos);
	assign wY = cUsiBusWidth'(qVPos);

	// Lowest index wins, so scan from the top down
	always_comb
	begin
		wColor = backColor;
		for (int i = pSquareNum - 1; i >= 0; i--)
		begin
			if (sqAlpha[i] >= cAlphaOpaque
				&& wX >= sqLeft[i] && wX <= sqRight[i]
				&& wY >= sqTop[i] && wY <= sqUnder[i])
			begin
				wColor = sqColor[i];
			end
		end
	end

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			qHPos <= '0;
			qVPos <= '0;
			qRun  <= 1'b0;
			qVd   <= 1'b0;
			qFd   <= 1'b0;
		end
		else
		begin
			// Idle only at (0,0), enable looked at here
			if (!qRun)
			begin
				qRun <= enable;
			end
			if (wLoad)
			begin
				qVd <= qRun;
				if (qRun)
				begin
					qFd <= (qHPos == '0) && (qVPos == '0);
					// Advance, wrap at end of line and frame
					if (qHPos == lpPosW'(pVHA - 1))
					begin
						qHPos <= '0;
						if (qVPos == lpPosW'(pVVA - 1))
						begin
							qVPos <= '0;
							qRun  <= 1'b0;
						end
						else
						begin
							qVPos <= qVPos + 1'b1;
						end
					end
					else
					begin
						qHPos <= qHPos + 1'b1;
					end
				end
			end
		end
	end

	// Pixel payload
	always_ff @(posedge iSCLK)
	begin
		if (wLoad && qRun)
		begin
			qPd <= wColor;
		end
	end

	assign out.pd = qPd;
	assign out.vd = qVd;
	assign out.fd = qFd;
	assign vPos   = qVPos;

endmodule

`default_nettype wire

// ==== VideoStreamIf.sv ====
// Video pixel stream between pipeline stages: pixel, valid, frame flag, ready strobe
`default_nettype none

interface VideoStreamIf
	import VideoTxPkg::*;
();

	// Pixel word
	logic [cDstColorDepth-1:0] pd;
	// Valid level
	logic                      vd;
	// First pixel of frame
	logic                      fd;
	// Ready strobe from the sink
	logic                      rs;

	// Producer side
	modport source (output pd, output vd, output fd, input rs);
	// Consumer side
	modport sink (input pd, input vd, input fd, output rs);

endinterface

`default_nettype wire

// ==== VideoTftUnit.sv ====
// Video TFT unit: command and pixel words onto the 8080 style parallel panel bus
`default_nettype none

module VideoTftUnit
	import VideoTxPkg::*;
#(
	parameter int pVHA = 320,
	parameter int pVVA = 240
)(
	input  logic                      iSCLK,
	input  logic                      arstN,
	// Pixel stream from FIFO
	VideoStreamIf.sink                in,
	// Panel bus
	output logic [cDstColorDepth-1:0] dq,
	output logic                      wrx,
	output logic                      dcx,
	output logic                      csx,
	output logic                      rdx,
	output logic                      videoRst
);

	localparam int lpCntW = $clog2(pVHA * pVVA + 1);

	// --------------------------------------------------
	// State codes
	// --------------------------------------------------
	localparam logic [2:0] lpIdle  = 3'd0;
	localparam logic [2:0] lpCmdLo = 3'd1;
	localparam logic [2:0] lpCmdHi = 3'd2;
	localparam logic [2:0] lpPixLo = 3'd3;
	localparam logic [2:0] lpPixHi = 3'd4;

	logic [2:0]                qState;
	logic [lpCntW-1:0]         qCnt;
	logic [cDstColorDepth-1:0] qPix;
	logic [cDstColorDepth-1:0] qDq;
	logic                      qWrx;
	logic                      qDcx;
	logic                      qCsx;
	logic                      wLast;
	logic                      wTake;

	// Last pixel of the frame on the bus
	assign wLast = (qCnt == lpCntW'(pVHA * pVVA - 1));
	// Ready in idle, or back to back after a pixel unless the frame closes
	assign in.rs = (qState == lpIdle) || (qState == lpPixHi && !wLast);
	assign wTake = in.vd && in.rs;

	// Pixel held while the command goes out
	always_ff @(posedge iSCLK)
	begin
		if (wTake)
		begin
			qPix <= in.pd;
		end
	end

	// --------------------------------------------------
	// Bus sequencer, WRX low then high per word
	// --------------------------------------------------
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			qState <= lpIdle;
			qCnt   <= '0;
			qDq    <= '0;
			qWrx   <= 1'b1;
			qDcx   <= 1'b1;
			qCsx   <= 1'b1;
		end
		else
		begin
			case (qState)
				lpCmdLo:
				begin
					// Panel latches command here
					qWrx   <= 1'b1;
					qState <= lpCmdHi;
				end
				lpCmdHi:
				begin
					qDq    <= qPix;
					qDcx   <= 1'b1;
					qWrx   <= 1'b0;
					qState <= lpPixLo;
				end
				lpPixLo:
				begin
					qWrx   <= 1'b1;
					qState <= lpPixHi;
				end
				default:
				begin
					// Pixel done, count it and close frame on the last
					if (qState == lpPixHi)
					begin
						qState <= lpIdle;
						if (wLast)
						begin
							qCsx <= 1'b1;
							qCnt <= '0;
						end
						else
						begin
							qCnt <= qCnt + 1'b1;
						end
					end
					if (wTake)
					begin
						qCsx <= 1'b0;
						qWrx <= 1'b0;
						if (in.fd)
						begin
							// New frame starts with memory write command
							qDq    <= cRamWrCmd;
							qDcx   <= 1'b0;
							qCnt   <= '0;
							qState <= lpCmdLo;
						end
						else
						begin
							qDq    <= in.pd;
							qDcx   <= 1'b1;
							qState <= lpPixLo;
						end
					end
				end
			endcase
		end
	end

	assign dq       = qDq;
	assign wrx      = qWrx;
	assign dcx      = qDcx;
	assign csx      = qCsx;
	// Write only panel, never read, never reset
	assign rdx      = 1'b1;
	assign videoRst = 1'b1;

endmodule

`default_nettype wire

// ==== VideoTxBlock.sv ====
// Video transmit block top: register file, pixel generator, FIFO and TFT unit
`default_nettype none

module VideoTxBlock
	import VideoTxPkg::*;
#(
	parameter int pVHA       = 320,
	parameter int pVVA       = 240,
	parameter int pSquareNum = 2,
	parameter int pFifoDepth = 16
)(
	input  logic                      iSCLK,
	input  logic                      arstN,
	// USI register port
	input  logic                      usiWe,
	input  logic [cUsiBusWidth-1:0]   usiAdrs,
	input  logic [cUsiBusWidth-1:0]   usiWd,
	output logic [cUsiBusWidth-1:0]   usiRd,
	// Panel bus
	output logic [cDstColorDepth-1:0] videoDq,
	output logic                      videoWrx,
	output logic                      videoDcx,
	output logic                      videoCsx,
	output logic                      videoRdx,
	output logic                      videoRst
);

	localparam int lpPosW = fPosWidth(pVHA, pVVA);

	// --------------------------------------------------
	// Settings from register file
	// --------------------------------------------------
	logic                      enable;
	logic [cDstColorDepth-1:0] backColor;
	logic [cUsiBusWidth-1:0]   sqLeft  [pSquareNum];
	logic [cUsiBusWidth-1:0]   sqRight [pSquareNum];
	logic [cUsiBusWidth-1:0]   sqTop   [pSquareNum];
	logic [cUsiBusWidth-1:0]   sqUnder [pSquareNum];
	logic [cDstColorDepth-1:0] sqColor [pSquareNum];
	logic [cAlphaWidth-1:0]    sqAlpha [pSquareNum];
	logic [lpPosW-1:0]         vPos;

	// Generator to FIFO, FIFO to TFT
	VideoStreamIf genStream ();
	VideoStreamIf tftStream ();

	VideoTxCsr #(
		.pVHA(pVHA), .pVVA(pVVA), .pSquareNum(pSquareNum)
	) u_VideoTxCsr (
		.iSCLK(iSCLK), .arstN(arstN),
		.usiWe(usiWe), .usiAdrs(usiAdrs), .usiWd(usiWd), .usiRd(usiRd),
		.vPos(vPos),
		.enable(enable), .backColor(backColor),
		.sqLeft(sqLeft), .sqRight(sqRight), .sqTop(sqTop), .sqUnder(sqUnder),
		.sqColor(sqColor), .sqAlpha(sqAlpha)
	);

	VideoPixelGenUnit #(
		.pVHA(pVHA), .pVVA(pVVA), .pSquareNum(pSquareNum)
	) u_VideoPixelGenUnit (
		.iSCLK(iSCLK), .arstN(arstN),
		.enable(enable), .backColor(backColor),
		.sqLeft(sqLeft), .sqRight(sqRight), .sqTop(sqTop), .sqUnder(sqUnder),
		.sqColor(sqColor), .sqAlpha(sqAlpha),
		.vPos(vPos),
		.out(genStream.source)
	);

	VideoTxFifo #(
		.pFifoDepth(pFifoDepth)
	) u_VideoTxFifo (
		.iSCLK(iSCLK), .arstN(arstN),
		.wr(genStream.sink),
		.rd(tftStream.source)
	);

	VideoTftUnit #(
		.pVHA(pVHA), .pVVA(pVVA)
	) u_VideoTftUnit (
		.iSCLK(iSCLK), .arstN(arstN),
		.in(tftStream.sink),
		.dq(videoDq), .wrx(videoWrx), .dcx(videoDcx), .csx(videoCsx),
		.rdx(videoRdx), .videoRst(videoRst)
	);

endmodule

`default_nettype wire

// ==== VideoTxBlockTb.sv ====
// Video transmit block testbench: register access, panel bus capture and frame checks
`default_nettype none

module VideoTxBlockTb
	import VideoTxPkg::*;
();

	localparam int lpVHA        = 8;
	localparam int lpVVA        = 4;
	localparam int lpSquareNum  = 2;
	localparam int lpFifoDepth  = 4;
	localparam int lpFrameWords = 1 + lpVHA * lpVVA;
	// Four frames of bus words plus slack, then register traffic
	localparam int lpTimeout    = 4 * (lpFrameWords * 2 + 40) + 200;

	logic        iSCLK;
	logic        arstN;
	logic        usiWe;
	logic [15:0] usiAdrs;
	logic [15:0] usiWd;
	logic [15:0] usiRd;
	logic [15:0] videoDq;
	logic        videoWrx;
	logic        videoDcx;
	logic        videoCsx;
	logic        videoRdx;
	logic        videoRst;

	// Copies of what was written, for the reference model
	logic [15:0] shBack;
	logic [15:0] shLeft  [lpSquareNum];
	logic [15:0] shRight [lpSquareNum];
	logic [15:0] shTop   [lpSquareNum];
	logic [15:0] shUnder [lpSquareNum];
	logic [15:0] shColor [lpSquareNum];
	logic [7:0]  shAlpha [lpSquareNum];

	// Words as {dcx, dq}
	logic [16:0] capQ [$];
	logic [16:0] expQ [$];
	logic [16:0] gotWord;
	logic [16:0] expWord;
	int          errCount     = 0;
	int          testFails    = 0;
	int          testNum      = 1;
	int          testErrStart = 0;
	int          cycleCnt     = 0;

	VideoTxBlock #(
		.pVHA(lpVHA), .pVVA(lpVVA), .pSquareNum(lpSquareNum), .pFifoDepth(lpFifoDepth)
	) u_VideoTxBlock (
		.iSCLK(iSCLK), .arstN(arstN),
		.usiWe(usiWe), .usiAdrs(usiAdrs), .usiWd(usiWd), .usiRd(usiRd),
		.videoDq(videoDq), .videoWrx(videoWrx), .videoDcx(videoDcx),
		.videoCsx(videoCsx), .videoRdx(videoRdx), .videoRst(videoRst)
	);

	always #20 iSCLK = ~iSCLK;

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	// First opaque covering square wins, bounds inclusive
	function automatic logic [15:0] refColor(input int x, input int y);
		for (int i = 0; i < lpSquareNum; i++)
		begin
			if (shAlpha[i] >= cAlphaOpaque
				&& x >= int'(shLeft[i]) && x <= int'(shRight[i])
				&& y >= int'(shTop[i]) && y <= int'(shUnder[i]))
			begin
				return shColor[i];
			end
		end
		return shBack;
	endfunction

	// --------------------------------------------------
	// Register access, entered and left 2 units after an edge
	// --------------------------------------------------
	task automatic writeReg(input logic [15:0] adrs, input logic [15:0] wd);
		usiWe   = 1'b1;
		usiAdrs = adrs;
		usiWd   = wd;
		@(posedge iSCLK);
		#2;
		usiWe = 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [15:0] exp, input logic [15:0] got);
		if (got !== exp)
		begin
			errCount++;
			$display("CHECK FAILED time %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// Read data registered, valid one cycle later
	task automatic checkRead(input logic [15:0] adrs, input logic [15:0] exp);
		usiAdrs = adrs;
		@(posedge iSCLK);
		#2;
		checkValue($sformatf("usiRd[%h]", adrs), exp, usiRd);
	endtask

	task automatic waitCycles(input int n);
		repeat (n)
		begin
			@(posedge iSCLK);
			#2;
		end
	endtask

	task automatic writeSquare(input int i, input logic [15:0] l, input logic [15:0] r,
		input logic [15:0] t, input logic [15:0] u, input logic [15:0] c, input logic [7:0] a);
		logic [15:0] base;
		base       = cRegSquareBase + 16'(i * 8);
		shLeft[i]  = l;
		shRight[i] = r;
		shTop[i]   = t;
		shUnder[i] = u;
		shColor[i] = c;
		shAlpha[i] = a;
		writeReg(base | 16'(cSqLeft), l);
		writeReg(base | 16'(cSqRight), r);
		writeReg(base | 16'(cSqTop), t);
		writeReg(base | 16'(cSqUnder), u);
		writeReg(base | 16'(cSqColor), c);
		writeReg(base | 16'(cSqAlpha), {8'h00, a});
	endtask

	task automatic writeBack(input logic [15:0] c);
		shBack = c;
		writeReg(cRegBack, c);
	endtask

	// Command word, then raster order pixels
	task automatic expectFrame();
		expQ.push_back({1'b0, cRamWrCmd});
		for (int y = 0; y < lpVVA; y++)
		begin
			for (int x = 0; x < lpVHA; x++)
			begin
				expQ.push_back({1'b1, refColor(x, y)});
			end
		end
	endtask

	// Start one frame, clear enable after holdCycles, wait for csx rising
	task automatic runFrame(input int holdCycles);
		expectFrame();
		writeReg(cRegCtrl, 16'h0001);
		@(negedge videoCsx);
		@(posedge iSCLK);
		#2;
		waitCycles(holdCycles);
		writeReg(cRegCtrl, 16'h0000);
		@(posedge videoCsx);
		@(posedge iSCLK);
		#2;
		if (expQ.size() != 0)
		begin
			errCount++;
			$display("Frame ended at %0t with %0d panel words missing", $time, expQ.size());
			expQ.delete();
		end
	endtask

	task automatic endTest(input string name);
		if (errCount == testErrStart)
		begin
			$display("Test %0d %s: pass", testNum, name);
		end
		else
		begin
			testFails++;
			$display("Test %0d %s: fail, %0d errors", testNum, name, errCount - testErrStart);
		end
		testNum++;
		testErrStart = errCount;
	endtask

	// --------------------------------------------------
	// Panel bus monitor and compare
	// --------------------------------------------------
	// Panel latches on WRX rising
	always @(posedge videoWrx)
	begin
		if (arstN === 1'b1)
		begin
			capQ.push_back({videoDcx, videoDq});
		end
	end

	always @(negedge iSCLK)
	begin
		while (capQ.size() > 0)
		begin
			gotWord = capQ.pop_front();
			if (expQ.size() == 0)
			begin
				errCount++;
				$display("Unexpected panel word %h with dcx %b at %0t",
					gotWord[15:0], gotWord[16], $time);
			end
			else
			begin
				expWord = expQ.pop_front();
				if (gotWord[16] !== expWord[16])
				begin
					errCount++;
					$display("CHECK FAILED time %0t videoDcx expected %b got %b",
						$time, expWord[16], gotWord[16]);
				end
				if (gotWord[15:0] !== expWord[15:0])
				begin
					errCount++;
					$display("CHECK FAILED time %0t videoDq expected %h got %h",
						$time, expWord[15:0], gotWord[15:0]);
				end
			end
		end
	end

	// Run limit
	initial
	begin
		while (cycleCnt < lpTimeout)
		begin
			@(posedge iSCLK);
			cycleCnt++;
		end
		$display("Timeout after %0d cycles, a frame never completed", cycleCnt);
		$display("Errors found");
		$finish;
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		logic [15:0] adrs;
		logic [15:0] val;
		int          px;
		int          py;
		logic [15:0] c0;
		void'($urandom(32'h721fcd24));
		iSCLK   = 1'b0;
		arstN   = 1'b0;
		usiWe   = 1'b0;
		usiAdrs = '0;
		usiWd   = '0;
		repeat (3) @(posedge iSCLK);
		#2;
		arstN = 1'b1;

		// Idle bus levels, then quiet while disabled
		checkValue("videoWrx", 16'h0001, 16'(videoWrx));
		checkValue("videoCsx", 16'h0001, 16'(videoCsx));
		checkValue("videoDcx", 16'h0001, 16'(videoDcx));
		checkValue("videoRdx", 16'h0001, 16'(videoRdx));
		checkValue("videoRst", 16'h0001, 16'(videoRst));
		checkValue("videoDq", 16'h0000, videoDq);
		waitCycles(50);
		checkValue("videoCsx", 16'h0001, 16'(videoCsx));
		endTest("reset state");

		writeBack(16'hA5C3);
		checkRead(cRegBack, 16'hA5C3);
		checkRead(cRegCtrl, 16'h0000);
		for (int i = 0; i < lpSquareNum; i++)
		begin
			for (int k = 0; k < 6; k++)
			begin
				adrs = cRegSquareBase + 16'(i * 8 + k);
				val  = 16'(16'h1357 * adrs);
				writeReg(adrs, val);
				// Alpha field only 8 bits wide
				checkRead(adrs, (k == 5) ? {8'h00, val[7:0]} : val);
			end
		end
		// Unused slot offset and out of map
		writeReg(16'h0016, 16'hFFFF);
		checkRead(16'h0016, 16'h0000);
		writeReg(16'h0030, 16'hBEEF);
		checkRead(16'h0030, 16'h0000);
		checkRead(16'h0005, 16'h0000);
		endTest("register readback");

		// Both squares below threshold
		writeBack(16'h07E0);
		writeSquare(0, 16'd0, 16'd7, 16'd0, 16'd3, 16'hF800, 8'h7F);
		writeSquare(1, 16'd2, 16'd5, 16'd1, 16'd2, 16'h001F, 8'h10);
		runFrame(0);
		endTest("background frame");

		// Both squares cover (px, py), so they overlap
		px = int'($urandom_range(lpVHA - 1, 0));
		py = int'($urandom_range(lpVVA - 1, 0));
		c0 = 16'($urandom);
		for (int i = 0; i < lpSquareNum; i++)
		begin
			writeSquare(i,
				16'($urandom_range(px, 0)), 16'($urandom_range(lpVHA - 1, px)),
				16'($urandom_range(py, 0)), 16'($urandom_range(lpVVA - 1, py)),
				(i == 0) ? c0 : ~c0, 8'(8'h80 + $urandom_range(127, 0)));
		end
		writeBack(16'($urandom));
		runFrame(0);
		endTest("rectangle frame");

		// Clear enable mid frame, then no new command
		runFrame(20);
		waitCycles(60);
		checkValue("videoCsx", 16'h0001, 16'(videoCsx));
		endTest("disable between frames");

		checkRead(cRegStatus, 16'h0000);
		endTest("status");

		$display("Tests run %0d, failed %0d, check errors %0d", testNum - 1, testFails, errCount);
		if (errCount == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== VideoTxBlock_props.sv ====
// Video transmit block assertions: panel bus WRX pulse, data hold and FIFO overflow
`default_nettype none

module VideoTxBlockProps
	import VideoTxPkg::*;
#(
	parameter int pDepth = 4
)(
	input  logic                      iSCLK,
	input  logic                      arstN,
	input  logic                      wrx,
	input  logic                      csx,
	input  logic [cDstColorDepth-1:0] dq,
	input  logic [$clog2(pDepth):0]   fifoCount,
	// Generator output register
	input  logic                      genVd,
	input  logic [cDstColorDepth-1:0] genPd,
	input  logic                      genFd
);

	// WRX low for a single cycle
	assert property (@(posedge iSCLK) disable iff (!arstN) !wrx |=> wrx)
		else $error("WRX low for two cycles");

	// Data held until WRX rises
	assert property (@(posedge iSCLK) disable iff (!arstN) !wrx |=> $stable(dq))
		else $error("DQ changed while WRX low");

	// Strobe only inside chip select
	assert property (@(posedge iSCLK) disable iff (!arstN) !wrx |-> !csx)
		else $error("WRX low with CSX high");

	// Full FIFO takes nothing, so the generator word stays put
	assert property (@(posedge iSCLK) disable iff (!arstN)
		(genVd && fifoCount == ($clog2(pDepth) + 1)'(pDepth))
		|=> (genVd && $stable(genPd) && $stable(genFd)))
		else $error("Pixel lost while FIFO full");

endmodule

bind VideoTxBlock VideoTxBlockProps #(
	.pDepth(pFifoDepth)
) u_VideoTxBlockProps (
	.iSCLK(iSCLK), .arstN(arstN),
	.wrx(videoWrx), .csx(videoCsx), .dq(videoDq),
	.fifoCount(u_VideoTxFifo.qCount),
	.genVd(u_VideoPixelGenUnit.qVd), .genPd(u_VideoPixelGenUnit.qPd),
	.genFd(u_VideoPixelGenUnit.qFd)
);

`default_nettype wire

// ==== VideoTxCsr.sv ====
// Video transmit register file: panel settings behind the USI write and read port
`default_nettype none

module VideoTxCsr
	import VideoTxPkg::*;
#(
	parameter int pVHA       = 320,
	parameter int pVVA       = 240,
	parameter int pSquareNum = 2,
	localparam int lpPosW    = fPosWidth(pVHA, pVVA)
)(
	input  logic                      iSCLK,
	input  logic                      arstN,
	// USI port
	input  logic                      usiWe,
	input  logic [cUsiBusWidth-1:0]   usiAdrs,
	input  logic [cUsiBusWidth-1:0]   usiWd,
	output logic [cUsiBusWidth-1:0]   usiRd,
	// Status from generator
	input  logic [lpPosW-1:0]         vPos,
	// Settings toward generator
	output logic                      enable,
	output logic [cDstColorDepth-1:0] backColor,
	output logic [cUsiBusWidth-1:0]   sqLeft  [pSquareNum],
	output logic [cUsiBusWidth-1:0]   sqRight [pSquareNum],
	output logic [cUsiBusWidth-1:0]   sqTop   [pSquareNum],
	output logic [cUsiBusWidth-1:0]   sqUnder [pSquareNum],
	output logic [cDstColorDepth-1:0] sqColor [pSquareNum],
	output logic [cAlphaWidth-1:0]    sqAlpha [pSquareNum]
);

	// --------------------------------------------------
	// Rectangle address decode
	// --------------------------------------------------
	logic [cUsiBusWidth-1:0] wSqOfs;
	logic [cUsiBusWidth-4:0] wSqIdx;
	logic                    wSqHit;
	logic [cUsiBusWidth-1:0] wRdData;

	// Offset from base, slot index in upper bits
	assign wSqOfs = usiAdrs - cRegSquareBase;
	assign wSqIdx = wSqOfs[cUsiBusWidth-1:3];
	// Inside the rectangle window
	assign wSqHit = (usiAdrs >= cRegSquareBase)
		&& (wSqOfs < cUsiBusWidth'(pSquareNum * 8));

	// --------------------------------------------------
	// Write side
	// --------------------------------------------------
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			enable    <= 1'b0;
			backColor <= '0;
			for (int i = 0; i < pSquareNum; i++)
			begin
				sqLeft[i]  <= '0;
				sqRight[i] <= '0;
				sqTop[i]   <= '0;
				sqUnder[i] <= '0;
				sqColor[i] <= '0;
				sqAlpha[i] <= '0;
			end
		end
		else if (usiWe)
		begin
			if (usiAdrs == cRegCtrl)
			begin
				enable <= usiWd[0];
			end
			if (usiAdrs == cRegBack)
			begin
				backColor <= usiWd[cDstColorDepth-1:0];
			end
			// Offsets 6 and 7 unused
			for (int i = 0; i < pSquareNum; i++)
			begin
				if (wSqHit && wSqIdx == i)
				begin
					case (usiAdrs[2:0])
						cSqLeft:  sqLeft[i]  <= usiWd;
						cSqRight: sqRight[i] <= usiWd;
						cSqTop:   sqTop[i]   <= usiWd;
						cSqUnder: sqUnder[i] <= usiWd;
						cSqColor: sqColor[i] <= usiWd[cDstColorDepth-1:0];
						cSqAlpha: sqAlpha[i] <= usiWd[cAlphaWidth-1:0];
						default:  ;
					endcase
				end
			end
		end
	end

	// --------------------------------------------------
	// Read side
	// --------------------------------------------------
	// Unmapped addresses fall through as zero
	always_comb
	begin
		wRdData = '0;
		case (usiAdrs)
			cRegCtrl:   wRdData = cUsiBusWidth'(enable);
			cRegBack:   wRdData = cUsiBusWidth'(backColor);
			cRegStatus: wRdData = cUsiBusWidth'(vPos);
			default:    ;
		endcase
		for (int i = 0; i < pSquareNum; i++)
		begin
			if (wSqHit && wSqIdx == i)
			begin
				case (usiAdrs[2:0])
					cSqLeft:  wRdData = sqLeft[i];
					cSqRight: wRdData = sqRight[i];
					cSqTop:   wRdData = sqTop[i];
					cSqUnder: wRdData = sqUnder[i];
					cSqColor: wRdData = cUsiBusWidth'(sqColor[i]);
					cSqAlpha: wRdData = cUsiBusWidth'(sqAlpha[i]);
					default:  ;
				endcase
			end
		end
	end

	// Registered read data, one cycle after address
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			usiRd <= '0;
		end
		else
		begin
			usiRd <= wRdData;
		end
	end

endmodule

`default_nettype wire

// ==== VideoTxFifo.sv ====
// Video pixel FIFO: single clock buffer of pixel and frame flag with full and empty
`default_nettype none

module VideoTxFifo
	import VideoTxPkg::*;
#(
	parameter int pFifoDepth = 16
)(
	input  logic        iSCLK,
	input  logic        arstN,
	// From generator
	VideoStreamIf.sink   wr,
	// Toward TFT unit
	VideoStreamIf.source rd
);

	localparam int lpAw = $clog2(pFifoDepth);

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------
	// Frame flag kept above the pixel
	logic [cDstColorDepth:0] mem [pFifoDepth];
	logic [lpAw-1:0]         qWrPtr;
	logic [lpAw-1:0]         qRdPtr;
	logic [lpAw:0]           qCount;
	logic                    wPush;
	logic                    wPop;

	assign wr.rs = (qCount != (lpAw+1)'(pFifoDepth));
	assign rd.vd = (qCount != '0);
	assign wPush = wr.vd && wr.rs;
	assign wPop  = rd.vd && rd.rs;

	always_ff @(posedge iSCLK)
	begin
		if (wPush)
		begin
			mem[qWrPtr] <= {wr.fd, wr.pd};
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			qWrPtr <= '0;
			qRdPtr <= '0;
			qCount <= '0;
		end
		else
		begin
			if (wPush)
			begin
				qWrPtr <= qWrPtr + 1'b1;
			end
			if (wPop)
			begin
				qRdPtr <= qRdPtr + 1'b1;
			end
			case ({wPush, wPop})
				2'b10:   qCount <= qCount + 1'b1;
				2'b01:   qCount <= qCount - 1'b1;
				default: ;
			endcase
		end
	end

	// Head entry, visible the cycle after the write
	assign {rd.fd, rd.pd} = mem[qRdPtr];

endmodule

`default_nettype wire

// ==== VideoTxPkg.sv ====
// Video transmit package: register map, colour widths and panel command code
`default_nettype none

package VideoTxPkg;

	// --------------------------------------------------
	// Data widths
	// --------------------------------------------------
	// RGB565 on the panel side
	localparam int cDstColorDepth = 16;
	localparam int cAlphaWidth    = 8;
	// USI data and address width
	localparam int cUsiBusWidth   = 16;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------
	localparam logic [cUsiBusWidth-1:0] cRegCtrl       = 16'h0000;
	localparam logic [cUsiBusWidth-1:0] cRegBack       = 16'h0001;
	// Read only, current line
	localparam logic [cUsiBusWidth-1:0] cRegStatus     = 16'h0002;
	// Eight addresses per rectangle
	localparam logic [cUsiBusWidth-1:0] cRegSquareBase = 16'h0010;

	// Offsets inside one rectangle slot
	localparam logic [2:0] cSqLeft  = 3'd0;
	localparam logic [2:0] cSqRight = 3'd1;
	localparam logic [2:0] cSqTop   = 3'd2;
	localparam logic [2:0] cSqUnder = 3'd3;
	localparam logic [2:0] cSqColor = 3'd4;
	localparam logic [2:0] cSqAlpha = 3'd5;

	// Draw threshold, no blending
	localparam logic [cAlphaWidth-1:0] cAlphaOpaque = 8'h80;

	// Panel memory write command
	localparam logic [cDstColorDepth-1:0] cRamWrCmd = 16'h002C;

	// Position counter width, wide enough for both raster dimensions
	function automatic int fPosWidth(input int h, input int v);
		return $clog2((h > v ? h : v) + 1);
	endfunction

endpackage

`default_nettype wire

// ==== all.f ====
VideoTxPkg.sv
VideoStreamIf.sv
VideoTxCsr.sv
VideoPixelGenUnit.sv
VideoTxFifo.sv
VideoTftUnit.sv
VideoTxBlock.sv
VideoTxBlock_props.sv
VideoTxBlockTb.sv
